// File: sig_gen_top.f
+incdir+dv
logic/sig_gen_pkg.sv
logic/sig_ctrl_if.sv
logic/pulse_ctrl.sv
logic/ctrl_align.sv
logic/sig_lane.sv
logic/sig_gen_top.sv
dv/sig_gen_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing -j 0 \
	-f sig_gen_top.f \
	--top-module sig_gen_tb \
	-o sig_gen_sim

output=$(./obj_dir/sig_gen_sim || true)
echo "$output"

if grep -q "STATUS: PASS" <<< "$output"; then
	exit 0
else
	exit 1
fi

// File: dv/sig_gen_model.svh
`ifndef SIG_GEN_MODEL_SVH
`define SIG_GEN_MODEL_SVH

// Envelope word {imag, real} for one lane, hashed from the whole address.
function automatic logic [31:0] env_word(input logic [15:0] addr, input int lane);
	logic [31:0] x;
	x = SEED ^ {addr, addr} ^ (32'(lane) << 8);
	x = xorshift(xorshift(x));
	return x;
endfunction

// Complex product, upper 16 bits of each 32-bit sum.
function automatic logic [31:0] cplx_product(input logic [31:0] car, input logic [31:0] env);
	logic signed [15:0] ar;
	logic signed [15:0] ai;
	logic signed [15:0] er;
	logic signed [15:0] ei;
	logic signed [31:0] re;
	logic signed [31:0] im;
	ar = car[15:0];
	ai = car[31:16];
	er = env[15:0];
	ei = env[31:16];
	re = ar * er - ai * ei;
	im = ar * ei + ai * er;
	return {im[31:16], re[31:16]};
endfunction

function automatic logic [31:0] pick_source(input logic [1:0] src, input logic [31:0] car,
	input logic [31:0] env);
	case (src)
		sig_gen_pkg::SRC_PROD:    return cplx_product(car, env);
		sig_gen_pkg::SRC_CARRIER: return car;
		sig_gen_pkg::SRC_ENV:     return env;
		default:                  return 32'h0;
	endcase
endfunction

// Q15 gain, bits 30 to 15 of the signed product.
function automatic logic [15:0] gain_part(input logic [15:0] v, input logic [15:0] gain);
	logic signed [31:0] p;
	p = $signed(v) * $signed(gain);
	return p[30:15];
endfunction

function automatic logic [15:0] expected_beat(input logic [31:0] car, input logic [31:0] env,
	input logic [1:0] src, input logic [15:0] gain, input logic outsel);
	logic [31:0] sel;
	sel = pick_source(src, car, env);
	if (outsel) begin
		return gain_part(sel[31:16], gain);
	end
	return gain_part(sel[15:0], gain);
endfunction

`endif

// File: dv/sig_gen_tb.sv
module sig_gen_tb;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int N_DDS = 4;
	localparam int MEM_LAT = 2;
	localparam int HIST = 64;
	localparam int NROWS = 9;
	localparam int SW = sig_gen_pkg::SAMPLE_W;
	localparam int CW = sig_gen_pkg::CPLX_W;
	localparam logic [31:0] SEED = 32'h61df1852;

	typedef struct packed {
		logic [15:0] start;
		logic [15:0] len;
		logic [15:0] gain;
		logic [1:0]  src;
		logic        stdy;
		logic        outsel;
		logic        burst;
	} row_t;

	logic clk;
	logic rstn;
	logic fifo_empty_i;
	logic [sig_gen_pkg::CMD_W-1:0] fifo_dout_i;
	logic fifo_rd_en_o;
	logic [sig_gen_pkg::ADDR_W-1:0] mem_addr_o;
	logic [N_DDS*SW-1:0] mem_dout_real_i;
	logic [N_DDS*SW-1:0] mem_dout_imag_i;
	logic [N_DDS*CW-1:0] carrier_i;
	logic outsel_i;
	logic m_axis_tready_i;
	logic m_axis_tvalid_o;
	logic [N_DDS*SW-1:0] m_axis_tdata_o;

	// Models and scoreboard state.
	row_t fifo_q[$];
	row_t beat_cmds[$];
	logic [15:0] addr_hist [HIST];
	logic [N_DDS*CW-1:0] carrier_hist [HIST];
	logic [SW-1:0] last_beat [N_DDS];
	logic [31:0] rng;
	logic last_stdy;
	logic active;
	int n;

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	`include "sig_gen_model.svh"

	// Stimulus table with one command per row.
	function automatic row_t table_row(input int i);
		case (i)
			0:       return '{16'h0010, 16'd12, 16'h7FFF, sig_gen_pkg::SRC_PROD, 1'b0, 1'b0, 1'b0};
			1:       return '{16'h0100, 16'd8, 16'h4000, sig_gen_pkg::SRC_PROD, 1'b0, 1'b0, 1'b0};
			2:       return '{16'h0200, 16'd6, 16'h7FFF, sig_gen_pkg::SRC_CARRIER, 1'b1, 1'b1, 1'b0};
			3:       return '{16'h0300, 16'd6, 16'h4000, sig_gen_pkg::SRC_ENV, 1'b1, 1'b1, 1'b0};
			4:       return '{16'h0400, 16'd5, 16'h7FFF, sig_gen_pkg::SRC_ZERO, 1'b0, 1'b0, 1'b0};
			5:       return '{16'hFFFC, 16'd7, 16'h2345, sig_gen_pkg::SRC_PROD, 1'b0, 1'b1, 1'b0};
			6:       return '{16'h0050, 16'd3, 16'hC000, sig_gen_pkg::SRC_ENV, 1'b1, 1'b1, 1'b1};
			7:       return '{16'h0060, 16'd0, 16'h0000, sig_gen_pkg::SRC_PROD, 1'b0, 1'b1, 1'b1};
			default: return '{16'h0070, 16'd4, 16'h7FFF, sig_gen_pkg::SRC_CARRIER, 1'b1, 1'b1, 1'b1};
		endcase
	endfunction

	function automatic logic [sig_gen_pkg::CMD_W-1:0] make_cmd(input row_t r);
		logic [sig_gen_pkg::CMD_W-1:0] c;
		c = '0;
		c[sig_gen_pkg::CMD_ADDR_LSB +: 16] = r.start;
		c[sig_gen_pkg::CMD_LEN_LSB +: 16] = r.len;
		c[sig_gen_pkg::CMD_GAIN_LSB +: 16] = r.gain;
		c[sig_gen_pkg::CMD_SRC_LSB +: 2] = r.src;
		c[sig_gen_pkg::CMD_STDY_BIT] = r.stdy;
		return c;
	endfunction

	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display("STATUS: FAIL");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_sample(input string name, input logic [SW-1:0] got,
		input logic [SW-1:0] exp);
		if (got !== exp) begin
			fail_run($sformatf("CHECK FAILED %s got %h expected %h", name, got, exp));
		end
	endtask

	task automatic check_addr(input string name, input logic [sig_gen_pkg::ADDR_W-1:0] got,
		input logic [sig_gen_pkg::ADDR_W-1:0] exp);
		if (got !== exp) begin
			fail_run($sformatf("CHECK FAILED %s got %h expected %h", name, got, exp));
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			fail_run($sformatf("CHECK FAILED %s got %h expected %h", name, got, exp));
		end
	endtask

	task automatic check_count(input string name, input int got, input int exp);
		if (got != exp) begin
			fail_run($sformatf("CHECK FAILED %s got %h expected %h", name, got, exp));
		end
	endtask

	// Waits until every command has streamed, then checks the idle tdata.
	task automatic wait_idle();
		do begin
			@(posedge clk);
		end while (fifo_q.size() != 0 || beat_cmds.size() != 0);
		repeat (12) @(negedge clk);
		for (int l = 0; l < N_DDS; l++) begin
			check_sample($sformatf("idle m_axis_tdata_o lane %0d", l),
				m_axis_tdata_o[l*SW +: SW], last_stdy ? '0 : last_beat[l]);
		end
	endtask

	sig_gen_top #(
		.N_DDS   (N_DDS),
		.MEM_LAT (MEM_LAT)
	) sig_gen_top_inst (
		.clk             (clk),
		.rstn            (rstn),
		.fifo_empty_i    (fifo_empty_i),
		.fifo_dout_i     (fifo_dout_i),
		.fifo_rd_en_o    (fifo_rd_en_o),
		.mem_addr_o      (mem_addr_o),
		.mem_dout_real_i (mem_dout_real_i),
		.mem_dout_imag_i (mem_dout_imag_i),
		.carrier_i       (carrier_i),
		.outsel_i        (outsel_i),
		.m_axis_tready_i (m_axis_tready_i),
		.m_axis_tvalid_o (m_axis_tvalid_o),
		.m_axis_tdata_o  (m_axis_tdata_o)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// FIFO and memory models, carrier source and beat checker.
	initial begin : drive_monitor
		row_t cmd;
		logic prev_rd;
		logic prev_valid;
		int beat_idx;
		logic [15:0] addr;
		logic [31:0] env;
		logic [N_DDS*CW-1:0] car_word;
		prev_rd = 1'b0;
		prev_valid = 1'b0;
		beat_idx = 0;
		forever begin
			@(negedge clk);
			n++;
			if (active) begin
				if (fifo_rd_en_o) begin
					if (prev_rd) begin
						fail_run("read strobe held high for more than one cycle");
					end else if (fifo_q.size() == 0) begin
						fail_run("read strobe while the FIFO was empty");
					end else begin
						cmd = fifo_q.pop_front();
						last_stdy = cmd.stdy;
						if (cmd.len != '0) begin
							beat_cmds.push_back(cmd);
						end
					end
				end
				prev_rd = fifo_rd_en_o;
				if (m_axis_tvalid_o) begin
					if (beat_cmds.size() == 0) begin
						fail_run("tvalid high with no command outstanding");
					end else begin
						cmd = beat_cmds[0];
						addr = cmd.start + beat_idx[15:0];
						car_word = carrier_hist[(n - sig_gen_pkg::LANE_LAT) % HIST];
						for (int l = 0; l < N_DDS; l++) begin
							last_beat[l] = expected_beat(car_word[l*CW +: CW], env_word(addr, l),
								cmd.src, cmd.gain, cmd.outsel);
							check_sample($sformatf("m_axis_tdata_o lane %0d beat %0d", l, beat_idx),
								m_axis_tdata_o[l*SW +: SW], last_beat[l]);
						end
						beat_idx++;
					end
				end else if (prev_valid) begin
					check_count("beat count", beat_idx, int'(beat_cmds[0].len));
					void'(beat_cmds.pop_front());
					beat_idx = 0;
				end
				prev_valid = m_axis_tvalid_o;
			end
			// Drive inputs for the next rising edge.
			addr_hist[n % HIST] = mem_addr_o;
			for (int l = 0; l < N_DDS; l++) begin
				rng = xorshift(rng);
				car_word[l*CW +: CW] = rng;
			end
			carrier_i = car_word;
			carrier_hist[n % HIST] = car_word;
			// Memory data lags its address by MEM_LAT cycles.
			addr = addr_hist[(n - MEM_LAT) % HIST];
			for (int l = 0; l < N_DDS; l++) begin
				env = env_word(addr, l);
				mem_dout_real_i[l*SW +: SW] = env[15:0];
				mem_dout_imag_i[l*SW +: SW] = env[31:16];
			end
			fifo_empty_i = (fifo_q.size() == 0);
			if (fifo_q.size() != 0) begin
				fifo_dout_i = make_cmd(fifo_q[0]);
				outsel_i = fifo_q[0].outsel;
			end
		end
	end

	initial begin : watchdog
		int limit;
		row_t r;
		limit = 16 + 40;
		for (int i = 0; i < NROWS; i++) begin
			r = table_row(i);
			limit += int'(r.len) + 40;
		end
		repeat (limit) @(posedge clk);
		fail_run("run timed out before all commands completed");
	end

	initial begin
		rstn = 1'b0;
		fifo_empty_i = 1'b1;
		fifo_dout_i = '0;
		mem_dout_real_i = '0;
		mem_dout_imag_i = '0;
		carrier_i = '0;
		outsel_i = 1'b0;
		m_axis_tready_i = 1'b1;
		rng = SEED;
		n = 100;
		active = 1'b0;
		last_stdy = 1'b0;
		for (int l = 0; l < N_DDS; l++) begin
			last_beat[l] = '0;
		end
		repeat (16) @(negedge clk);
		rstn = 1'b1;
		active = 1'b1;
		// Quiet outputs with the FIFO empty.
		repeat (10) begin
			@(negedge clk);
			check_flag("m_axis_tvalid_o", m_axis_tvalid_o, 1'b0);
			check_flag("fifo_rd_en_o", fifo_rd_en_o, 1'b0);
			check_addr("mem_addr_o", mem_addr_o, '0);
			for (int l = 0; l < N_DDS; l++) begin
				check_sample($sformatf("m_axis_tdata_o lane %0d", l),
					m_axis_tdata_o[l*SW +: SW], '0);
			end
		end
		for (int i = 0; i < NROWS; i++) begin
			row_t r;
			r = table_row(i);
			if (!r.burst) begin
				wait_idle();
			end
			@(posedge clk);
			fifo_q.push_back(r);
		end
		wait_idle();
		$display("STATUS: PASS");
		$finish;
	end

endmodule

// File: logic/sig_gen_top.sv
module sig_gen_top #(
	parameter int N_DDS   = 4,
	parameter int MEM_LAT = 2
) (
	input  logic                                   clk,
	input  logic                                   rstn,

	// Command FIFO, first word fall through.
	input  logic                                   fifo_empty_i,
	input  logic [sig_gen_pkg::CMD_W-1:0]          fifo_dout_i,
	output logic                                   fifo_rd_en_o,

	// Envelope memory.
	output logic [sig_gen_pkg::ADDR_W-1:0]         mem_addr_o,
	input  logic [N_DDS*sig_gen_pkg::SAMPLE_W-1:0] mem_dout_real_i,
	input  logic [N_DDS*sig_gen_pkg::SAMPLE_W-1:0] mem_dout_imag_i,

	// One complex carrier sample per lane.
	input  logic [N_DDS*sig_gen_pkg::CPLX_W-1:0]   carrier_i,
	input  logic                                   outsel_i,

	// AXI stream output.
	input  logic                                   m_axis_tready_i,
	output logic                                   m_axis_tvalid_o,
	output logic [N_DDS*sig_gen_pkg::SAMPLE_W-1:0] m_axis_tdata_o
);

	// Controller side and lane side of the alignment.
	sig_ctrl_if cmd_if ();
	sig_ctrl_if lane_if ();

	// Aligned en is read at the gain stage, two stages ahead of tdata.
	logic [1:0] valid_q;

	pulse_ctrl pulse_ctrl_inst (
		.clk          (clk),
		.rstn         (rstn),
		.fifo_empty_i (fifo_empty_i),
		.fifo_dout_i  (fifo_dout_i),
		.fifo_rd_en_o (fifo_rd_en_o),
		.mem_addr_o   (mem_addr_o),
		.ctrl         (cmd_if.ctrl)
	);

	ctrl_align #(
		.MEM_LAT (MEM_LAT)
	) ctrl_align_inst (
		.clk       (clk),
		.rstn      (rstn),
		.src_side  (cmd_if.align_in),
		.lane_side (lane_if.ctrl)
	);

	for (genvar g = 0; g < N_DDS; g++) begin : g_lane
		sig_lane sig_lane_inst (
			.clk        (clk),
			.rstn       (rstn),
			.carrier_i  (carrier_i[g*sig_gen_pkg::CPLX_W +: sig_gen_pkg::CPLX_W]),
			.env_real_i (mem_dout_real_i[g*sig_gen_pkg::SAMPLE_W +: sig_gen_pkg::SAMPLE_W]),
			.env_imag_i (mem_dout_imag_i[g*sig_gen_pkg::SAMPLE_W +: sig_gen_pkg::SAMPLE_W]),
			.outsel_i   (outsel_i),
			.ctrl       (lane_if.lane),
			.dout_o     (m_axis_tdata_o[g*sig_gen_pkg::SAMPLE_W +: sig_gen_pkg::SAMPLE_W])
		);
	end

	always_ff @(posedge clk) begin
		if (!rstn) begin
			valid_q <= '0;
		end else begin
			valid_q <= {valid_q[0], lane_if.en};
		end
	end

	// No back-pressure, so tready is not used.
	assign m_axis_tvalid_o = valid_q[1];

endmodule

// File: logic/sig_lane.sv
module sig_lane (
	input  logic                             clk,
	input  logic                             rstn,
	input  logic [sig_gen_pkg::CPLX_W-1:0]   carrier_i,
	input  logic [sig_gen_pkg::SAMPLE_W-1:0] env_real_i,
	input  logic [sig_gen_pkg::SAMPLE_W-1:0] env_imag_i,
	input  logic                             outsel_i,
	sig_ctrl_if.lane                         ctrl,
	output logic [sig_gen_pkg::SAMPLE_W-1:0] dout_o
);

	// Stage 1 registers the inputs.
	logic signed [sig_gen_pkg::SAMPLE_W-1:0] car_re_q;
	logic signed [sig_gen_pkg::SAMPLE_W-1:0] car_im_q;
	logic signed [sig_gen_pkg::SAMPLE_W-1:0] env_re_q;
	logic signed [sig_gen_pkg::SAMPLE_W-1:0] env_im_q;

	// Stage 2 holds partial products and delayed raw samples.
	logic signed [sig_gen_pkg::CPLX_W-1:0] pp_rr_q;
	logic signed [sig_gen_pkg::CPLX_W-1:0] pp_ii_q;
	logic signed [sig_gen_pkg::CPLX_W-1:0] pp_ri_q;
	logic signed [sig_gen_pkg::CPLX_W-1:0] pp_ir_q;
	logic [sig_gen_pkg::CPLX_W-1:0]        car2_q;
	logic [sig_gen_pkg::CPLX_W-1:0]        env2_q;

	// Stage 3 forms the product and the source mux.
	logic signed [sig_gen_pkg::CPLX_W-1:0] sum_re;
	logic signed [sig_gen_pkg::CPLX_W-1:0] sum_im;
	logic [sig_gen_pkg::CPLX_W-1:0]        prod;
	logic [sig_gen_pkg::CPLX_W-1:0]        sel;
	logic [sig_gen_pkg::CPLX_W-1:0]        mux_q;

	// Stage 4 holds the gain products.
	logic signed [sig_gen_pkg::CPLX_W-1:0] gp_re_q;
	logic signed [sig_gen_pkg::CPLX_W-1:0] gp_im_q;

	// Stage 5 selects the part into the output register.
	logic                             en_q;
	logic [sig_gen_pkg::SAMPLE_W-1:0] part;
	logic [sig_gen_pkg::SAMPLE_W-1:0] dout_q;

	always_ff @(posedge clk) begin
		car_re_q <= carrier_i[sig_gen_pkg::SAMPLE_W-1:0];
		car_im_q <= carrier_i[sig_gen_pkg::CPLX_W-1:sig_gen_pkg::SAMPLE_W];
		env_re_q <= env_real_i;
		env_im_q <= env_imag_i;

		pp_rr_q <= car_re_q * env_re_q;
		pp_ii_q <= car_im_q * env_im_q;
		pp_ri_q <= car_re_q * env_im_q;
		pp_ir_q <= car_im_q * env_re_q;
		car2_q  <= {car_im_q, car_re_q};
		env2_q  <= {env_im_q, env_re_q};

		mux_q <= sel;

		// Products hold between commands.
		if (ctrl.en) begin
			gp_re_q <= $signed(mux_q[sig_gen_pkg::SAMPLE_W-1:0]) * $signed(ctrl.gain);
			gp_im_q <= $signed(mux_q[sig_gen_pkg::CPLX_W-1:sig_gen_pkg::SAMPLE_W])
				* $signed(ctrl.gain);
		end
	end

	// Upper half of each sum of (a+jb)(c+jd).
	assign sum_re = pp_rr_q - pp_ii_q;
	assign sum_im = pp_ri_q + pp_ir_q;
	assign prod = {sum_im[sig_gen_pkg::CPLX_W-1:sig_gen_pkg::SAMPLE_W],
		sum_re[sig_gen_pkg::CPLX_W-1:sig_gen_pkg::SAMPLE_W]};

	always_comb begin
		case (ctrl.src)
			sig_gen_pkg::SRC_PROD:    sel = prod;
			sig_gen_pkg::SRC_CARRIER: sel = car2_q;
			sig_gen_pkg::SRC_ENV:     sel = env2_q;
			sig_gen_pkg::SRC_ZERO:    sel = '0;
		endcase
	end

	// Drop the duplicate sign bit to keep Q15.
	assign part = outsel_i
		? gp_im_q[sig_gen_pkg::CPLX_W-2:sig_gen_pkg::SAMPLE_W-1]
		: gp_re_q[sig_gen_pkg::CPLX_W-2:sig_gen_pkg::SAMPLE_W-1];

	always_ff @(posedge clk) begin
		if (!rstn) begin
			en_q   <= 1'b0;
			dout_q <= '0;
		end else begin
			en_q <= ctrl.en;
			if (en_q) begin
				dout_q <= part;
			end else if (ctrl.stdy) begin
				dout_q <= '0;
			end
		end
	end

	assign dout_o = dout_q;

endmodule

// File: logic/ctrl_align.sv
module ctrl_align #(
	parameter int MEM_LAT = 2
) (
	input  logic        clk,
	input  logic        rstn,
	sig_ctrl_if.align_in src_side,
	sig_ctrl_if.ctrl     lane_side
);

	// Memory latency plus the lane stage where each field is read.
	localparam int SRC_DLY  = MEM_LAT + sig_gen_pkg::LANE_LAT - 3;
	localparam int GAIN_DLY = MEM_LAT + sig_gen_pkg::LANE_LAT - 2;
	localparam int STDY_DLY = MEM_LAT + sig_gen_pkg::LANE_LAT - 1;

	logic [sig_gen_pkg::SRC_W-1:0]    src_q  [SRC_DLY];
	logic [sig_gen_pkg::SAMPLE_W-1:0] gain_q [GAIN_DLY];
	logic                             en_q   [GAIN_DLY];
	logic                             stdy_q [STDY_DLY];

	always_ff @(posedge clk) begin
		if (!rstn) begin
			for (int i = 0; i < SRC_DLY; i++) begin
				src_q[i] <= '0;
			end
			for (int i = 0; i < GAIN_DLY; i++) begin
				gain_q[i] <= '0;
				en_q[i]   <= 1'b0;
			end
			for (int i = 0; i < STDY_DLY; i++) begin
				stdy_q[i] <= 1'b0;
			end
		end else begin
			src_q[0]  <= src_side.src;
			gain_q[0] <= src_side.gain;
			en_q[0]   <= src_side.en;
			stdy_q[0] <= src_side.stdy;
			for (int i = 1; i < SRC_DLY; i++) begin
				src_q[i] <= src_q[i-1];
			end
			for (int i = 1; i < GAIN_DLY; i++) begin
				gain_q[i] <= gain_q[i-1];
				en_q[i]   <= en_q[i-1];
			end
			for (int i = 1; i < STDY_DLY; i++) begin
				stdy_q[i] <= stdy_q[i-1];
			end
		end
	end

	// Src at the mux, gain and en at the gain stage, stdy at the output.
	assign lane_side.src  = src_q[SRC_DLY-1];
	assign lane_side.gain = gain_q[GAIN_DLY-1];
	assign lane_side.en   = en_q[GAIN_DLY-1];
	assign lane_side.stdy = stdy_q[STDY_DLY-1];

endmodule

// File: logic/pulse_ctrl.sv
module pulse_ctrl (
	input  logic                             clk,
	input  logic                             rstn,
	input  logic                             fifo_empty_i,
	input  logic [sig_gen_pkg::CMD_W-1:0]    fifo_dout_i,
	output logic                             fifo_rd_en_o,
	output logic [sig_gen_pkg::ADDR_W-1:0]   mem_addr_o,
	sig_ctrl_if.ctrl                         ctrl
);

	// Command fields, valid while the FIFO is not empty.
	logic [sig_gen_pkg::ADDR_W-1:0]   cmd_start;
	logic [sig_gen_pkg::ADDR_W-1:0]   cmd_len;
	logic [sig_gen_pkg::SAMPLE_W-1:0] cmd_gain;
	logic [sig_gen_pkg::SRC_W-1:0]    cmd_src;
	logic                             cmd_stdy;

	// FSM state, high while addresses are swept.
	logic run_q;
	logic rd_en_q;
	logic pop;

	logic [sig_gen_pkg::ADDR_W-1:0]   addr_q;
	logic [sig_gen_pkg::ADDR_W-1:0]   left_q;
	logic [sig_gen_pkg::SAMPLE_W-1:0] gain_q;
	logic [sig_gen_pkg::SRC_W-1:0]    src_q;
	logic                             stdy_q;

	assign cmd_start = fifo_dout_i[sig_gen_pkg::CMD_ADDR_LSB +: sig_gen_pkg::ADDR_W];
	assign cmd_len   = fifo_dout_i[sig_gen_pkg::CMD_LEN_LSB +: sig_gen_pkg::ADDR_W];
	assign cmd_gain  = fifo_dout_i[sig_gen_pkg::CMD_GAIN_LSB +: sig_gen_pkg::SAMPLE_W];
	assign cmd_src   = fifo_dout_i[sig_gen_pkg::CMD_SRC_LSB +: sig_gen_pkg::SRC_W];
	assign cmd_stdy  = fifo_dout_i[sig_gen_pkg::CMD_STDY_BIT];

	// The strobe just issued has not popped the word yet.
	assign pop = !run_q && !rd_en_q && !fifo_empty_i;

	always_ff @(posedge clk) begin
		if (!rstn) begin
			run_q   <= 1'b0;
			rd_en_q <= 1'b0;
			addr_q  <= '0;
			left_q  <= '0;
			gain_q  <= '0;
			src_q   <= '0;
			stdy_q  <= 1'b0;
		end else begin
			rd_en_q <= pop;
			if (pop) begin
				stdy_q <= cmd_stdy;
				// Zero length only changes steady mode.
				if (cmd_len != '0) begin
					run_q  <= 1'b1;
					addr_q <= cmd_start;
					left_q <= cmd_len - 1'b1;
					gain_q <= cmd_gain;
					src_q  <= cmd_src;
				end
			end else if (run_q) begin
				if (left_q == '0) begin
					run_q <= 1'b0;
				end else begin
					addr_q <= addr_q + 1'b1;
					left_q <= left_q - 1'b1;
				end
			end
		end
	end

	assign fifo_rd_en_o = rd_en_q;
	assign mem_addr_o   = addr_q;

	// Control fields leave with the address they belong to.
	assign ctrl.gain = gain_q;
	assign ctrl.src  = src_q;
	assign ctrl.stdy = stdy_q;
	assign ctrl.en   = run_q;

endmodule

// File: logic/sig_ctrl_if.sv
interface sig_ctrl_if;

	// Gain applied after the source mux.
	logic [sig_gen_pkg::SAMPLE_W-1:0] gain;

	// Source select and steady mode.
	logic [sig_gen_pkg::SRC_W-1:0] src;
	logic stdy;

	// High while a command streams samples.
	logic en;

	modport ctrl (output gain, output src, output stdy, output en);
	modport align_in (input gain, input src, input stdy, input en);
	modport lane (input gain, input src, input stdy, input en);

endinterface

// File: logic/sig_gen_pkg.sv
package sig_gen_pkg;

	// One real or imaginary component.
	localparam int SAMPLE_W = 16;

	// Complex sample, imaginary in the upper half.
	localparam int CPLX_W = 2 * SAMPLE_W;

	// Envelope memory address, also the width of the length field.
	localparam int ADDR_W = 16;

	// Command word.
	localparam int CMD_W = 64;

	// Command field positions.
	localparam int CMD_ADDR_LSB = 0;
	localparam int CMD_LEN_LSB = 16;
	localparam int CMD_GAIN_LSB = 32;
	localparam int CMD_SRC_LSB = 48;
	localparam int CMD_STDY_BIT = 50;

	// Output source select.
	localparam int SRC_W = 2;
	localparam logic [SRC_W-1:0] SRC_PROD = 2'd0;
	localparam logic [SRC_W-1:0] SRC_CARRIER = 2'd1;
	localparam logic [SRC_W-1:0] SRC_ENV = 2'd2;
	localparam logic [SRC_W-1:0] SRC_ZERO = 2'd3;

	// Register stages inside one lane, input sample to output.
	localparam int LANE_LAT = 5;

endpackage
